/* fc_irq_pkg.sv */
`default_nettype none

package fc_irq_pkg;

    //************************************************************
    //*** widths and vector types
    //************************************************************

    // event / interrupt id, also used for the core's ack index
    typedef logic [4:0] irq_id_t;

    // RI5CY std fast lines
    typedef logic [14:0] irq_fast_t;

    // RI5CY extended fast lines
    typedef logic [31:0] irq_fastx_t;

    // arbiter output towards remap and core side
    typedef struct packed {
        logic    req;  // an interrupt is presented
        irq_id_t id;   // event id of the winner
    } irq_req_t;

    //************************************************************
    //*** ids and masks
    //************************************************************

    // SoC event FIFO shows up as this event id
    localparam irq_id_t IRQ_ID_SOC_FIFO = 5'd26;

    // ids covered by the remap tables
    //   0..12  sw events, dma, timer lo/hi, pf
    //   14,15  ref clock, gpio
    //   17..20 adv timer
    //   26     SoC FIFO
    //   29..31 fc err, fc hp events
    localparam logic [31:0] IRQ_VALID_MASK = 32'hE41E_DFFF;

    //************************************************************
    //*** default sizes
    //************************************************************

    localparam int EVENT_ID_WIDTH_DEF = 8;  // FIFO data word
    localparam int FIFO_DEPTH_DEF     = 4;  // FIFO entries

endpackage

`default_nettype wire

/* fc_event_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module fc_event_fifo #(
    parameter int EVENT_ID_WIDTH = fc_irq_pkg::EVENT_ID_WIDTH_DEF,
    parameter int FIFO_DEPTH     = fc_irq_pkg::FIFO_DEPTH_DEF
) (
    input  logic                      clk_i,
    input  logic                      rst_i,

    input  logic                      push_i,
    input  logic [EVENT_ID_WIDTH-1:0] push_data_i,
    input  logic                      pop_i,

    output logic [EVENT_ID_WIDTH-1:0] head_data_o,
    output logic                      empty_o,     // state after this edge
    output logic                      fulln_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [EVENT_ID_WIDTH-1:0] mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0]          wr_ptr_q;
    logic [PTR_W-1:0]          rd_ptr_q;
    logic [CNT_W-1:0]          count_q;
    logic [CNT_W-1:0]          count_d;
    logic                      push_ok;
    logic                      pop_ok;

    // wrap at FIFO_DEPTH, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push_ok = push_i && (count_q != CNT_W'(FIFO_DEPTH)); // full drops the word
    assign pop_ok  = pop_i && (count_q != '0);

    always_comb begin
        count_d = count_q;
        if (push_ok && !pop_ok) begin
            count_d = count_q + 1'b1;
        end else if (!push_ok && pop_ok) begin
            count_d = count_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop_ok) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            count_q <= count_d;
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    assign head_data_o = mem_q[rd_ptr_q];

    // look-ahead flag so the arbiter can track the FIFO on the same edge
    assign empty_o = (count_d == '0);
    assign fulln_o = (count_q != CNT_W'(FIFO_DEPTH));

endmodule

`default_nettype wire

/* fc_irq_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module fc_irq_arbiter #(
    parameter int EVENT_ID_WIDTH = fc_irq_pkg::EVENT_ID_WIDTH_DEF
) (
    input  logic                      clk_i,
    input  logic                      rst_i,

    input  logic [31:0]               events_i,
    input  logic                      fifo_empty_i,  // look-ahead from the FIFO
    input  logic [EVENT_ID_WIDTH-1:0] fifo_head_i,

    input  logic                      ack_i,
    input  fc_irq_pkg::irq_id_t       ack_id_i,

    output logic                      fifo_pop_o,
    output fc_irq_pkg::irq_req_t      irq_req_o,

    output logic [EVENT_ID_WIDTH-1:0] fifo_event_data_o,
    output logic                      fifo_event_valid_o
);

    logic [31:0]               pending_q;
    logic [31:0]               pending_d;
    logic [31:0]               event_set;
    logic [31:0]               ack_clr;
    fc_irq_pkg::irq_req_t      req_q;
    fc_irq_pkg::irq_req_t      req_d;
    logic [EVENT_ID_WIDTH-1:0] fifo_data_q;
    logic                      fifo_valid_q;

    //************************************************************
    //*** pending set
    //************************************************************

    // unmapped ids and the FIFO line are never latched from events_i
    always_comb begin
        event_set = events_i & fc_irq_pkg::IRQ_VALID_MASK;
        event_set[fc_irq_pkg::IRQ_ID_SOC_FIFO] = 1'b0;
    end

    always_comb begin
        ack_clr = '0;
        if (ack_i) begin
            ack_clr[ack_id_i] = 1'b1;
        end
    end

    always_comb begin
        // a fresh event on the acked line stays pending
        pending_d = (pending_q & ~ack_clr) | event_set;
        pending_d[fc_irq_pkg::IRQ_ID_SOC_FIFO] = !fifo_empty_i;
    end

    // only pop what is actually there
    assign fifo_pop_o = ack_i &&
                        (ack_id_i == fc_irq_pkg::IRQ_ID_SOC_FIFO) &&
                        pending_q[fc_irq_pkg::IRQ_ID_SOC_FIFO];

    //************************************************************
    //*** highest id wins
    //************************************************************

    always_comb begin
        req_d = '0;
        for (int i = 0; i < 32; i++) begin
            if (pending_d[i]) begin  // later hits overwrite, top id stays
                req_d.req = 1'b1;
                req_d.id  = fc_irq_pkg::irq_id_t'(i);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q    <= '0;
            req_q        <= '0;
            fifo_valid_q <= 1'b0;
        end else begin
            pending_q    <= pending_d;
            req_q        <= req_d;
            fifo_valid_q <= fifo_pop_o;  // one cycle pulse per popped word
        end
    end

    //************************************************************
    //*** popped FIFO word
    //************************************************************

    always_ff @(posedge clk_i) begin
        if (fifo_pop_o) begin
            fifo_data_q <= fifo_head_i;
        end
    end

    assign irq_req_o          = req_q;
    assign fifo_event_data_o  = fifo_data_q;
    assign fifo_event_valid_o = fifo_valid_q;

endmodule

`default_nettype wire

/* fc_irq_remap.sv */
`timescale 1ns/1ps
`default_nettype none

module fc_irq_remap (
    input  fc_irq_pkg::irq_req_t   irq_req_i,
    input  fc_irq_pkg::irq_id_t    ack_idx_i,   // fastx numbering from the core

    output fc_irq_pkg::irq_fast_t  irq_fast_o,
    output fc_irq_pkg::irq_fastx_t irq_fastx_o,
    output fc_irq_pkg::irq_id_t    ack_id_o
);

    //************************************************************
    //*** event id to std fast lines
    //************************************************************

    always_comb begin
        irq_fast_o = '0;
        if (irq_req_i.req) begin
            case (irq_req_i.id)
                5'd10: irq_fast_o[0]  = 1'b1;  // timer lo
                5'd11: irq_fast_o[1]  = 1'b1;  // timer hi
                5'd14: irq_fast_o[2]  = 1'b1;  // ref clock edge
                5'd15: irq_fast_o[3]  = 1'b1;  // gpio
                5'd17: irq_fast_o[4]  = 1'b1;  // adv timer 0
                5'd18: irq_fast_o[5]  = 1'b1;  // adv timer 1
                5'd19: irq_fast_o[6]  = 1'b1;  // adv timer 2
                5'd20: irq_fast_o[7]  = 1'b1;  // adv timer 3
                fc_irq_pkg::IRQ_ID_SOC_FIFO: irq_fast_o[10] = 1'b1;
                5'd29: irq_fast_o[11] = 1'b1;  // fc error
                5'd30: irq_fast_o[12] = 1'b1;  // fc hp 0
                5'd31: irq_fast_o[13] = 1'b1;  // fc hp 1
                default: irq_fast_o = '0;      // sw, dma, pf have no std line
            endcase
        end
    end

    //************************************************************
    //*** event id to fastx lines
    //************************************************************

    always_comb begin
        irq_fastx_o = '0;
        if (irq_req_i.req) begin
            case (irq_req_i.id)
                // low ids map straight through
                5'd0, 5'd1, 5'd2, 5'd3, 5'd4,
                5'd5, 5'd6, 5'd7, 5'd8, 5'd9,
                5'd12: irq_fastx_o[irq_req_i.id] = 1'b1;

                // std fast lines sit at 16 and up
                5'd10: irq_fastx_o[16] = 1'b1;
                5'd11: irq_fastx_o[17] = 1'b1;
                5'd14: irq_fastx_o[18] = 1'b1;
                5'd15: irq_fastx_o[19] = 1'b1;
                5'd17: irq_fastx_o[20] = 1'b1;
                5'd18: irq_fastx_o[21] = 1'b1;
                5'd19: irq_fastx_o[22] = 1'b1;
                5'd20: irq_fastx_o[23] = 1'b1;
                fc_irq_pkg::IRQ_ID_SOC_FIFO: irq_fastx_o[26] = 1'b1;
                5'd29: irq_fastx_o[27] = 1'b1;
                5'd30: irq_fastx_o[28] = 1'b1;
                5'd31: irq_fastx_o[29] = 1'b1;
                default: irq_fastx_o = '0;
            endcase
        end
    end

    //************************************************************
    //*** core ack index back to event id
    //************************************************************

    always_comb begin
        case (ack_idx_i)
            5'd0, 5'd1, 5'd2, 5'd3, 5'd4,
            5'd5, 5'd6, 5'd7, 5'd8, 5'd9,
            5'd12: ack_id_o = ack_idx_i;  // identity range

            5'd16: ack_id_o = 5'd10;
            5'd17: ack_id_o = 5'd11;
            5'd18: ack_id_o = 5'd14;
            5'd19: ack_id_o = 5'd15;
            5'd20: ack_id_o = 5'd17;
            5'd21: ack_id_o = 5'd18;
            5'd22: ack_id_o = 5'd19;
            5'd23: ack_id_o = 5'd20;
            5'd26: ack_id_o = fc_irq_pkg::IRQ_ID_SOC_FIFO;
            5'd27: ack_id_o = 5'd29;
            5'd28: ack_id_o = 5'd30;
            5'd29: ack_id_o = 5'd31;
            default: ack_id_o = '0;  // unused fastx lines
        endcase
    end

endmodule

`default_nettype wire

/* fc_irq_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module fc_irq_subsystem #(
    parameter int EVENT_ID_WIDTH = fc_irq_pkg::EVENT_ID_WIDTH_DEF,
    parameter int FIFO_DEPTH     = fc_irq_pkg::FIFO_DEPTH_DEF
) (
    input  logic                      clk_i,
    input  logic                      rst_i,

    // SoC event FIFO write side
    input  logic                      event_fifo_valid_i,
    output logic                      event_fifo_fulln_o,
    input  logic [EVENT_ID_WIDTH-1:0] event_fifo_data_i,

    input  logic [31:0]               events_i,  // direct event lines

    // core side
    output fc_irq_pkg::irq_req_t      irq_req_o,
    output fc_irq_pkg::irq_fast_t     irq_fast_o,
    output fc_irq_pkg::irq_fastx_t    irq_fastx_o,
    input  logic                      irq_ack_i,
    input  fc_irq_pkg::irq_id_t       irq_ack_idx_i,

    // word taken with the FIFO interrupt
    output logic [EVENT_ID_WIDTH-1:0] fifo_event_data_o,
    output logic                      fifo_event_valid_o
);

    logic                      fifo_pop;
    logic                      fifo_empty;
    logic [EVENT_ID_WIDTH-1:0] fifo_head;
    fc_irq_pkg::irq_id_t       ack_id;

    //************************************************************
    //*** event FIFO
    //************************************************************

    fc_event_fifo #(
        .EVENT_ID_WIDTH ( EVENT_ID_WIDTH ),
        .FIFO_DEPTH     ( FIFO_DEPTH     )
    ) i_event_fifo (
        .clk_i       ( clk_i              ),
        .rst_i       ( rst_i              ),
        .push_i      ( event_fifo_valid_i ),
        .push_data_i ( event_fifo_data_i  ),
        .pop_i       ( fifo_pop           ),
        .head_data_o ( fifo_head          ),
        .empty_o     ( fifo_empty         ),
        .fulln_o     ( event_fifo_fulln_o )
    );

    //************************************************************
    //*** pending set and selection
    //************************************************************

    fc_irq_arbiter #(
        .EVENT_ID_WIDTH ( EVENT_ID_WIDTH )
    ) i_irq_arbiter (
        .clk_i              ( clk_i              ),
        .rst_i              ( rst_i              ),
        .events_i           ( events_i           ),
        .fifo_empty_i       ( fifo_empty         ),
        .fifo_head_i        ( fifo_head          ),
        .ack_i              ( irq_ack_i          ),
        .ack_id_i           ( ack_id             ),
        .fifo_pop_o         ( fifo_pop           ),
        .irq_req_o          ( irq_req_o          ),
        .fifo_event_data_o  ( fifo_event_data_o  ),
        .fifo_event_valid_o ( fifo_event_valid_o )
    );

    // id to RI5CY vectors, ack index back to id
    fc_irq_remap i_irq_remap (
        .irq_req_i   ( irq_req_o     ),
        .ack_idx_i   ( irq_ack_idx_i ),
        .irq_fast_o  ( irq_fast_o    ),
        .irq_fastx_o ( irq_fastx_o   ),
        .ack_id_o    ( ack_id        )
    );

endmodule

`default_nettype wire

/* tb_fc_irq_model.svh */
`ifndef TB_FC_IRQ_MODEL_SVH
`define TB_FC_IRQ_MODEL_SVH

//************************************************************
//*** reference model of the interrupt path
//************************************************************

int                        fast_bit  [32];  // -1 where the id has no std line
int                        fastx_bit [32];  // -1 for ids outside the tables
int                        ack_to_id [32];
logic [31:0]               line_mask;       // lines other than 26 that can go pending
logic [31:0]               m_pending;
logic [EVENT_ID_WIDTH-1:0] m_fifo [$];
logic                      m_req;
logic [4:0]                m_id;
logic                      m_valid;
logic [EVENT_ID_WIDTH-1:0] m_data;

task automatic model_init();
    int std_id    [12] = '{10, 11, 14, 15, 17, 18, 19, 20, 26, 29, 30, 31};
    int std_fast  [12] = '{0, 1, 2, 3, 4, 5, 6, 7, 10, 11, 12, 13};
    int std_fastx [12] = '{16, 17, 18, 19, 20, 21, 22, 23, 26, 27, 28, 29};
    line_mask = '0;
    for (int i = 0; i < 32; i++) begin
        fast_bit[i]  = -1;
        fastx_bit[i] = (i < 10 || i == 12) ? i : -1;  // low ids pass straight
        ack_to_id[i] = 0;                              // unused fastx lines
    end
    for (int i = 0; i < 12; i++) begin
        fast_bit[std_id[i]]  = std_fast[i];
        fastx_bit[std_id[i]] = std_fastx[i];
    end
    for (int i = 0; i < 32; i++) begin
        if (fastx_bit[i] >= 0) begin
            ack_to_id[fastx_bit[i]] = i;
            line_mask[i] = (i != 26);
        end
    end
    m_pending = '0;
    m_fifo.delete();
    m_req   = 1'b0;
    m_id    = '0;
    m_valid = 1'b0;
endtask

// one clock edge with the inputs the DUT sampled on it
task automatic model_edge(input logic [31:0] ev, input logic push,
                          input logic [EVENT_ID_WIDTH-1:0] data,
                          input logic ack, input logic [4:0] idx);
    int          ack_id;
    logic        push_ok;
    logic [31:0] pend;
    ack_id  = ack_to_id[idx];
    push_ok = push && (m_fifo.size() < FIFO_DEPTH);  // full FIFO drops the word
    m_valid = ack && (ack_id == 26) && (m_fifo.size() != 0);
    if (m_valid) begin
        m_data = m_fifo.pop_front();
    end
    if (push_ok) begin
        m_fifo.push_back(data);
    end
    if (ack && ack_id != 26) begin
        m_pending[ack_id] = 1'b0;
    end
    m_pending = m_pending | (ev & line_mask);  // new event beats the clear
    pend      = m_pending;
    pend[26]  = (m_fifo.size() != 0);
    m_req     = 1'b0;
    m_id      = '0;
    for (int i = 0; i < 32; i++) begin
        if (pend[i]) begin
            m_req = 1'b1;
            m_id  = 5'(i);
        end
    end
endtask

task automatic compare_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
        $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
        abort_run();
    end
endtask

`endif

/* tb_fc_irq_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fc_irq_subsystem;

    localparam int EVENT_ID_WIDTH = 8;
    localparam int FIFO_DEPTH     = 4;

    logic                      clk_i = 1'b0;
    logic                      rst_i;
    logic                      event_fifo_valid_i;
    logic                      event_fifo_fulln_o;
    logic [EVENT_ID_WIDTH-1:0] event_fifo_data_i;
    logic [31:0]               events_i;
    fc_irq_pkg::irq_req_t      irq_req_o;
    fc_irq_pkg::irq_fast_t     irq_fast_o;
    fc_irq_pkg::irq_fastx_t    irq_fastx_o;
    logic                      irq_ack_i;
    fc_irq_pkg::irq_id_t       irq_ack_idx_i;
    logic [EVENT_ID_WIDTH-1:0] fifo_event_data_o;
    logic                      fifo_event_valid_o;
    logic [31:0]               rng_state = 32'hc4e6;
    int                        ack_wait  = -1;  // core delay countdown or -1 when idle

    `include "tb_fc_irq_model.svh"

    fc_irq_subsystem #(
        .EVENT_ID_WIDTH ( EVENT_ID_WIDTH ),
        .FIFO_DEPTH     ( FIFO_DEPTH     )
    ) UUT (.*);

    always #5 clk_i = ~clk_i;

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_outputs();
        logic [31:0] exp_fast;
        logic [31:0] exp_fastx;
        exp_fast  = '0;
        exp_fastx = '0;
        if (m_req) begin
            if (fast_bit[m_id] >= 0) begin
                exp_fast[fast_bit[m_id]] = 1'b1;
            end
            exp_fastx[fastx_bit[m_id]] = 1'b1;
            compare_value("irq_req_o.id", irq_req_o.id, m_id);
        end
        compare_value("irq_req_o.req", irq_req_o.req, m_req);
        compare_value("irq_fast_o", irq_fast_o, exp_fast);
        compare_value("irq_fastx_o", irq_fastx_o, exp_fastx);
        compare_value("event_fifo_fulln_o", event_fifo_fulln_o, m_fifo.size() != FIFO_DEPTH);
        compare_value("fifo_event_valid_o", fifo_event_valid_o, m_valid);
        if (m_valid) begin
            compare_value("fifo_event_data_o", fifo_event_data_o, m_data);
        end
    endtask

    //************************************************************
    //*** one cycle of model edge, core response, drive and check
    //************************************************************

    task automatic step(input logic [31:0] ev, input logic push,
                        input logic [EVENT_ID_WIDTH-1:0] data, input logic auto_ack);
        logic       ack;
        logic [4:0] idx;
        @(posedge clk_i);
        model_edge(events_i, event_fifo_valid_i, event_fifo_data_i, irq_ack_i, irq_ack_idx_i);
        ack = 1'b0;
        idx = '0;
        if (auto_ack && m_req) begin
            if (ack_wait < 0) begin
                ack_wait = int'(next_rand() % 4);  // 0..3 cycles before the ack
            end
            if (ack_wait == 0) begin
                ack      = 1'b1;
                idx      = 5'(fastx_bit[m_id]);  // core acks in fastx numbering
                ack_wait = -1;
            end else begin
                ack_wait--;
            end
        end else begin
            ack_wait = -1;
        end
        events_i           <= ev;
        event_fifo_valid_i <= push;
        event_fifo_data_i  <= data;
        irq_ack_i          <= ack;
        irq_ack_idx_i      <= idx;
        @(negedge clk_i);
        check_outputs();
    endtask

    // ack everything until the request stays low
    task automatic drain_all();
        int cycles;
        cycles = 0;
        step('0, 1'b0, '0, 1'b1);
        while (irq_req_o.req) begin
            if (cycles == 300) begin
                $display("Timeout: interrupt request still high after 300 acknowledge cycles");
                abort_run();
            end
            step('0, 1'b0, '0, 1'b1);
            cycles++;
        end
    endtask

    initial begin
        logic [31:0]               r;
        logic [31:0]               ev;
        logic [EVENT_ID_WIDTH-1:0] data;
        model_init();
        rst_i              <= 1'b1;
        events_i           <= '0;
        event_fifo_valid_i <= 1'b0;
        event_fifo_data_i  <= '0;
        irq_ack_i          <= 1'b0;
        irq_ack_idx_i      <= '0;
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_outputs();  // reset state

        // every mapped line on its own
        for (int id = 0; id < 32; id++) begin
            if (line_mask[id]) begin
                step(32'd1 << id, 1'b0, '0, 1'b0);
                step('0, 1'b0, '0, 1'b0);
                compare_value("irq_req_o.id", irq_req_o.id, id);
                drain_all();
            end
        end

        step(32'hE01E_1C25, 1'b0, '0, 1'b0);  // several lines together
        drain_all();
        step(~line_mask, 1'b0, '0, 1'b0);     // unmapped lines and line 26
        step('0, 1'b0, '0, 1'b0);
        compare_value("irq_req_o.req", irq_req_o.req, 1'b0);

        //************************************************************
        //*** FIFO words and overflow
        //************************************************************

        for (int i = 0; i < 3; i++) begin
            step('0, 1'b1, EVENT_ID_WIDTH'(8'h30 + i), 1'b0);
        end
        step('0, 1'b0, '0, 1'b0);
        compare_value("irq_req_o.id", irq_req_o.id, 26);
        drain_all();
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            step('0, 1'b1, EVENT_ID_WIDTH'(8'hA0 + i), 1'b0);
        end
        step('0, 1'b0, '0, 1'b0);
        compare_value("event_fifo_fulln_o", event_fifo_fulln_o, 1'b0);
        drain_all();

        // random mix with sparse events
        for (int n = 0; n < 3000; n++) begin
            r  = next_rand();
            ev = '0;
            if (r[3:0] == 4'd0) begin
                ev = next_rand() & next_rand() & next_rand();
            end
            data = EVENT_ID_WIDTH'(next_rand());
            step(ev, r[6:4] < 3'd2, data, 1'b1);
        end
        drain_all();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* fc_irq_subsystem.f */
+incdir+.
fc_irq_pkg.sv
fc_event_fifo.sv
fc_irq_arbiter.sv
fc_irq_remap.sv
fc_irq_subsystem.sv
tb_fc_irq_subsystem.sv
